// File: hw/reg_bus_pkg.sv
/*
  Register bus widths shared by master, demux and slaves.
  Full-word accesses only, so there are no byte enables.
*/

`default_nettype none

package reg_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Byte address as issued by the master
  typedef logic [ADDR_W-1:0] addr_t;

  // Read and write data word
  typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// File: hw/ext_periph_pkg.sv
/*
  External peripheral address map and slave constants.
  Windows must not overlap. SLOW_RAM_WAIT must be 2 or more.
*/

`default_nettype none

package ext_periph_pkg;

  typedef logic [6:0] word_idx_t;
  typedef logic [0:0] slave_idx_t;

  localparam slave_idx_t SLOW_RAM_IDX = 1'b0;
  localparam slave_idx_t GPIO_CNT_IDX = 1'b1;
  localparam int unsigned NUM_SLAVES = 2;

  localparam reg_bus_pkg::addr_t SLOW_RAM_BASE = 32'h0000_0000;
  localparam reg_bus_pkg::addr_t SLOW_RAM_SIZE = 32'h0000_0200;
  localparam reg_bus_pkg::addr_t GPIO_CNT_BASE = 32'h0000_1000;
  localparam reg_bus_pkg::addr_t GPIO_CNT_SIZE = 32'h0000_0010;

  // Slow memory geometry and answer latency in cycles
  localparam int unsigned SLOW_RAM_WORDS = 128;
  localparam int unsigned SLOW_RAM_WAIT = 4;

  // Counter register offsets inside its window
  localparam reg_bus_pkg::addr_t GPIO_CNT_OFS_COUNT = 32'h0000_0000;
  localparam reg_bus_pkg::addr_t GPIO_CNT_OFS_MAX = 32'h0000_0004;
  localparam reg_bus_pkg::data_t GPIO_CNT_MAX_RESET = 32'd2048;

endpackage

`default_nettype wire

// File: hw/ext_periph_demux.sv
/*
  Combinational register bus demux. Slaves see the offset inside their window.
  Unmapped addresses get an immediate error reply with zero data.
*/

`timescale 1ns/1ps
`default_nettype none

module ext_periph_demux (
  input  wire logic               req_valid_i,
  input  wire logic               req_write_i,
  input  wire reg_bus_pkg::addr_t req_addr_i,
  input  wire reg_bus_pkg::data_t req_wdata_i,
  output logic                    rsp_ready_o,
  output reg_bus_pkg::data_t      rsp_rdata_o,
  output logic                    rsp_error_o,

  output logic                    ram_valid_o,
  output logic                    ram_write_o,
  output reg_bus_pkg::addr_t      ram_addr_o,
  output reg_bus_pkg::data_t      ram_wdata_o,
  input  wire logic               ram_ready_i,
  input  wire reg_bus_pkg::data_t ram_rdata_i,

  output logic                    cnt_valid_o,
  output logic                    cnt_write_o,
  output reg_bus_pkg::addr_t      cnt_addr_o,
  output reg_bus_pkg::data_t      cnt_wdata_o,
  input  wire logic               cnt_ready_i,
  input  wire reg_bus_pkg::data_t cnt_rdata_i
);

  reg_bus_pkg::addr_t ram_ofs;
  reg_bus_pkg::addr_t cnt_ofs;
  logic [ext_periph_pkg::NUM_SLAVES-1:0] hit;
  ext_periph_pkg::slave_idx_t sel;
  logic mapped;

  // Unsigned offset compare covers both window bounds
  assign ram_ofs = req_addr_i - ext_periph_pkg::SLOW_RAM_BASE;
  assign cnt_ofs = req_addr_i - ext_periph_pkg::GPIO_CNT_BASE;

  always_comb begin
    hit = '0;
    hit[ext_periph_pkg::SLOW_RAM_IDX] = ram_ofs < ext_periph_pkg::SLOW_RAM_SIZE;
    hit[ext_periph_pkg::GPIO_CNT_IDX] = cnt_ofs < ext_periph_pkg::GPIO_CNT_SIZE;
    sel = hit[ext_periph_pkg::GPIO_CNT_IDX] ? ext_periph_pkg::GPIO_CNT_IDX
                                            : ext_periph_pkg::SLOW_RAM_IDX;
  end

  assign mapped = |hit;

  // Only the addressed slave sees valid
  assign ram_valid_o = req_valid_i && mapped && (sel == ext_periph_pkg::SLOW_RAM_IDX);
  assign cnt_valid_o = req_valid_i && mapped && (sel == ext_periph_pkg::GPIO_CNT_IDX);

  assign ram_write_o = req_write_i;
  assign ram_addr_o  = ram_ofs;
  assign ram_wdata_o = req_wdata_i;
  assign cnt_write_o = req_write_i;
  assign cnt_addr_o  = cnt_ofs;
  assign cnt_wdata_o = req_wdata_i;

  always_comb begin
    rsp_ready_o = 1'b0;
    rsp_rdata_o = '0;
    rsp_error_o = 1'b0;
    if (!mapped) begin
      rsp_ready_o = req_valid_i;
      rsp_error_o = req_valid_i;
    end else if (sel == ext_periph_pkg::GPIO_CNT_IDX) begin
      rsp_ready_o = cnt_ready_i;
      rsp_rdata_o = cnt_rdata_i;
    end else begin
      rsp_ready_o = ram_ready_i;
      rsp_rdata_o = ram_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/slow_ram.sv
/*
  Word memory that answers SLOW_RAM_WAIT cycles after valid rises.
  Address bits 8:2 select the word. Contents are undefined after power-up.
*/

`timescale 1ns/1ps
`default_nettype none

module slow_ram (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               valid_i,
  input  wire logic               write_i,
  input  wire reg_bus_pkg::addr_t addr_i,
  input  wire reg_bus_pkg::data_t wdata_i,
  output logic                    ready_o,
  output reg_bus_pkg::data_t      rdata_o
);

  localparam int unsigned WAIT_W = $clog2(ext_periph_pkg::SLOW_RAM_WAIT);

  reg_bus_pkg::data_t mem_q [ext_periph_pkg::SLOW_RAM_WORDS];
  reg_bus_pkg::data_t rdata_q;
  ext_periph_pkg::word_idx_t word_idx;
  logic [WAIT_W-1:0] wait_q;
  logic ready_q;
  logic last_wait;
  logic access;

  assign word_idx  = addr_i[8:2];
  assign last_wait = wait_q == WAIT_W'(ext_periph_pkg::SLOW_RAM_WAIT - 1);

  // Pending transfer on its final wait cycle
  assign access = valid_i && !ready_q && last_wait;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_q  <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      if (valid_i && !ready_q) begin
        if (last_wait) begin
          wait_q  <= '0;
          ready_q <= 1'b1;
        end else begin
          wait_q <= wait_q + WAIT_W'(1);
        end
      end else begin
        wait_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (write_i) begin
        mem_q[word_idx] <= wdata_i;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/gpio_cnt.sv
/*
  Counts rising edges of an asynchronous GPIO input, answers bus reads at once.
  gpio_o pulses for one cycle when the count reaches MAX, then counting restarts.
*/

`timescale 1ns/1ps
`default_nettype none

module gpio_cnt (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               valid_i,
  input  wire logic               write_i,
  input  wire reg_bus_pkg::addr_t addr_i,
  input  wire reg_bus_pkg::data_t wdata_i,
  output logic                    ready_o,
  output reg_bus_pkg::data_t      rdata_o,
  input  wire logic               gpio_i,
  output logic                    gpio_o
);

  // Two sync stages plus one for edge detect
  logic [2:0] gpio_q;
  logic rise;
  reg_bus_pkg::data_t count_q;
  reg_bus_pkg::data_t max_q;
  reg_bus_pkg::data_t count_inc;
  logic sel_count;
  logic sel_max;
  logic pulse_q;

  assign rise      = gpio_q[1] && !gpio_q[2];
  assign count_inc = count_q + 32'd1;
  assign sel_count = addr_i == ext_periph_pkg::GPIO_CNT_OFS_COUNT;
  assign sel_max   = addr_i == ext_periph_pkg::GPIO_CNT_OFS_MAX;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_q  <= '0;
      count_q <= '0;
      max_q   <= ext_periph_pkg::GPIO_CNT_MAX_RESET;
      pulse_q <= 1'b0;
    end else begin
      gpio_q  <= {gpio_q[1:0], gpio_i};
      pulse_q <= 1'b0;
      if (valid_i && write_i && sel_count) begin
        // Clearing wins over a coincident edge
        count_q <= '0;
      end else if (rise) begin
        if (count_inc == max_q) begin
          count_q <= '0;
          pulse_q <= 1'b1;
        end else begin
          count_q <= count_inc;
        end
      end
      if (valid_i && write_i && sel_max) begin
        max_q <= wdata_i;
      end
    end
  end

  assign ready_o = valid_i;

  always_comb begin
    if (sel_count) begin
      rdata_o = count_q;
    end else if (sel_max) begin
      rdata_o = max_q;
    end else begin
      rdata_o = '0;
    end
  end

  assign gpio_o = pulse_q;

endmodule

`default_nettype wire

// File: hw/ext_periph_top.sv
/*
  Register bus subsystem with slow memory and GPIO counter.
  One transfer in flight; the master holds the request until ready.
*/

`timescale 1ns/1ps
`default_nettype none

module ext_periph_top (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               req_valid_i,
  input  wire logic               req_write_i,
  input  wire reg_bus_pkg::addr_t req_addr_i,
  input  wire reg_bus_pkg::data_t req_wdata_i,
  output logic                    rsp_ready_o,
  output reg_bus_pkg::data_t      rsp_rdata_o,
  output logic                    rsp_error_o,
  input  wire logic               gpio_i,
  output logic                    gpio_o
);

  logic ram_valid;
  logic ram_write;
  reg_bus_pkg::addr_t ram_addr;
  reg_bus_pkg::data_t ram_wdata;
  logic ram_ready;
  reg_bus_pkg::data_t ram_rdata;

  logic cnt_valid;
  logic cnt_write;
  reg_bus_pkg::addr_t cnt_addr;
  reg_bus_pkg::data_t cnt_wdata;
  logic cnt_ready;
  reg_bus_pkg::data_t cnt_rdata;

  ext_periph_demux ext_periph_demux_i (
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_ready_o (rsp_ready_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o),
    .ram_valid_o (ram_valid),
    .ram_write_o (ram_write),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_ready_i (ram_ready),
    .ram_rdata_i (ram_rdata),
    .cnt_valid_o (cnt_valid),
    .cnt_write_o (cnt_write),
    .cnt_addr_o  (cnt_addr),
    .cnt_wdata_o (cnt_wdata),
    .cnt_ready_i (cnt_ready),
    .cnt_rdata_i (cnt_rdata)
  );

  slow_ram slow_ram_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ram_valid),
    .write_i (ram_write),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .ready_o (ram_ready),
    .rdata_o (ram_rdata)
  );

  gpio_cnt gpio_cnt_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (cnt_valid),
    .write_i (cnt_write),
    .addr_i  (cnt_addr),
    .wdata_i (cnt_wdata),
    .ready_o (cnt_ready),
    .rdata_o (cnt_rdata),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

endmodule

`default_nettype wire

// File: verif/ext_periph_properties.sv
/*
  Bus and GPIO pulse assertions, bound into ext_periph_top.
  Bus checks are disabled while reset is low.
*/

`timescale 1ns/1ps
`default_nettype none

module ext_periph_properties (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic req_valid_i,
  input wire logic rsp_ready_o,
  input wire logic rsp_error_o,
  input wire logic gpio_o
);

  ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_ready_o |-> req_valid_i
  ) else $error("rsp_ready_o high while req_valid_i is low");

  error_needs_ready: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_error_o |-> rsp_ready_o
  ) else $error("rsp_error_o high without rsp_ready_o");

  // First cycle out of reset
  quiet_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> (!rsp_ready_o && !gpio_o)
  ) else $error("ready or gpio_o high in the cycle after reset");

  single_cycle_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) gpio_o |=> !gpio_o
  ) else $error("gpio_o high for two cycles running");

endmodule

bind ext_periph_top ext_periph_properties props_i (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .rsp_ready_o (rsp_ready_o),
  .rsp_error_o (rsp_error_o),
  .gpio_o      (gpio_o)
);

`default_nettype wire

// File: verif/tb_ext_periph.sv
/*
  Directed testbench for the register bus subsystem, stops at the first error.
  Memory words are only compared after the testbench has written them.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_ext_periph;

  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY = 2;
  localparam int RAM_LATENCY = 4;
  localparam int LEVEL_CYCLES = 5;
  localparam int RANDOM_WRITES = 16;
  // All tests together take well under a thousand cycles
  localparam int WATCHDOG_CYCLES = 4000;

  localparam reg_bus_pkg::addr_t CNT_COUNT_ADDR = 32'h0000_1000;
  localparam reg_bus_pkg::addr_t CNT_MAX_ADDR = 32'h0000_1004;
  localparam reg_bus_pkg::addr_t UNMAPPED_ADDR = 32'h0000_2000;

  logic clk_i;
  logic rst_n_i;
  logic req_valid_i;
  logic req_write_i;
  reg_bus_pkg::addr_t req_addr_i;
  reg_bus_pkg::data_t req_wdata_i;
  logic rsp_ready_o;
  reg_bus_pkg::data_t rsp_rdata_o;
  logic rsp_error_o;
  logic gpio_i;
  logic gpio_o;

  integer seed;
  int pulse_total = 0;
  reg_bus_pkg::data_t model_mem [128];
  logic [127:0] model_written;

  ext_periph_top uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_ready_o (rsp_ready_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o)
  );

  always #(CLK_HALF) clk_i = ~clk_i;

  // Output pulses over the whole run
  always @(negedge clk_i) begin
    if (rst_n_i && gpio_o) begin
      pulse_total++;
    end
  end

  task automatic abort_run(input string reason);
    $display("tests failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string what, input reg_bus_pkg::data_t got,
                             input reg_bus_pkg::data_t exp);
    assert (got === exp) else begin
      $display("FAILED at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      abort_run("value mismatch");
    end
  endtask

  function automatic reg_bus_pkg::addr_t word_addr(input logic [6:0] idx);
    return {23'd0, idx, 2'b00};
  endfunction

  // Starts and ends 2 ns after a rising edge; ready is sampled at the falling edge
  task automatic bus_xfer(input logic write, input reg_bus_pkg::addr_t addr,
                          input reg_bus_pkg::data_t wdata,
                          output reg_bus_pkg::data_t rdata, output logic error,
                          output int latency);
    logic done;
    done = 1'b0;
    latency = 0;
    rdata = '0;
    error = 1'b0;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i = addr;
    req_wdata_i = wdata;
    while (!done) begin
      @(negedge clk_i);
      if (rsp_ready_o) begin
        rdata = rsp_rdata_o;
        error = rsp_error_o;
        done = 1'b1;
      end else begin
        latency++;
      end
    end
    @(posedge clk_i);
    #(DRIVE_DELAY);
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
  endtask

  task automatic bus_write(input reg_bus_pkg::addr_t addr, input reg_bus_pkg::data_t wdata,
                           output logic error, output int latency);
    reg_bus_pkg::data_t unused_rdata;
    bus_xfer(1'b1, addr, wdata, unused_rdata, error, latency);
  endtask

  task automatic bus_read(input reg_bus_pkg::addr_t addr, output reg_bus_pkg::data_t rdata,
                          output logic error, output int latency);
    bus_xfer(1'b0, addr, '0, rdata, error, latency);
  endtask

  task automatic ram_write_checked(input logic [6:0] idx, input reg_bus_pkg::data_t wdata);
    logic error;
    int latency;
    bus_write(word_addr(idx), wdata, error, latency);
    check_value("memory write latency", reg_bus_pkg::data_t'(latency), RAM_LATENCY);
    check_value("memory write error", reg_bus_pkg::data_t'(error), 32'd0);
    model_mem[idx] = wdata;
    model_written[idx] = 1'b1;
  endtask

  task automatic ram_read_checked(input logic [6:0] idx);
    reg_bus_pkg::data_t rdata;
    logic error;
    int latency;
    bus_read(word_addr(idx), rdata, error, latency);
    check_value("memory read latency", reg_bus_pkg::data_t'(latency), RAM_LATENCY);
    check_value("memory read error", reg_bus_pkg::data_t'(error), 32'd0);
    check_value("memory read data", rdata, model_mem[idx]);
  endtask

  task automatic cnt_write_checked(input reg_bus_pkg::addr_t addr,
                                   input reg_bus_pkg::data_t wdata);
    logic error;
    int latency;
    bus_write(addr, wdata, error, latency);
    check_value("counter write latency", reg_bus_pkg::data_t'(latency), 32'd0);
    check_value("counter write error", reg_bus_pkg::data_t'(error), 32'd0);
  endtask

  task automatic cnt_read_checked(input reg_bus_pkg::addr_t addr,
                                  input reg_bus_pkg::data_t exp);
    reg_bus_pkg::data_t rdata;
    logic error;
    int latency;
    bus_read(addr, rdata, error, latency);
    check_value("counter read latency", reg_bus_pkg::data_t'(latency), 32'd0);
    check_value("counter read error", reg_bus_pkg::data_t'(error), 32'd0);
    check_value("counter read data", rdata, exp);
  endtask

  // One rising edge, each level held longer than the synchroniser delay
  task automatic gpio_rise_fall();
    gpio_i = 1'b1;
    repeat (LEVEL_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    gpio_i = 1'b0;
    repeat (LEVEL_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_value("ready after reset", reg_bus_pkg::data_t'(rsp_ready_o), 32'd0);
    check_value("error after reset", reg_bus_pkg::data_t'(rsp_error_o), 32'd0);
    check_value("gpio_o after reset", reg_bus_pkg::data_t'(gpio_o), 32'd0);
    @(posedge clk_i);
    #(DRIVE_DELAY);
    cnt_read_checked(CNT_MAX_ADDR, 32'd2048);
  endtask

  task automatic test_ram_single();
    ram_write_checked(7'h10, 32'hA5A5_1234);
    ram_read_checked(7'h10);
  endtask

  task automatic test_ram_random();
    logic [6:0] idx;
    logic [6:0] first_idx;
    first_idx = '0;
    for (int i = 0; i < RANDOM_WRITES; i++) begin
      if (i == RANDOM_WRITES - 1) begin
        idx = 7'h7F;
      end else if (i == 8) begin
        // Overwrite an earlier word
        idx = first_idx;
      end else begin
        idx = 7'($random(seed));
      end
      if (i == 0) begin
        first_idx = idx;
      end
      ram_write_checked(idx, reg_bus_pkg::data_t'($random(seed)));
    end
    for (int i = 0; i < 128; i++) begin
      idx = 7'(i);
      if (model_written[idx]) begin
        ram_read_checked(idx);
      end
    end
  endtask

  task automatic test_unmapped();
    reg_bus_pkg::data_t rdata;
    logic error;
    int latency;
    // Word that the unmapped address aliases to in bits 8:2
    ram_write_checked(7'h00, 32'h0F0F_5A5A);
    bus_read(UNMAPPED_ADDR, rdata, error, latency);
    check_value("unmapped read latency", reg_bus_pkg::data_t'(latency), 32'd0);
    check_value("unmapped read error", reg_bus_pkg::data_t'(error), 32'd1);
    check_value("unmapped read data", rdata, 32'd0);
    bus_write(UNMAPPED_ADDR, 32'hDEAD_BEEF, error, latency);
    check_value("unmapped write latency", reg_bus_pkg::data_t'(latency), 32'd0);
    check_value("unmapped write error", reg_bus_pkg::data_t'(error), 32'd1);
    ram_read_checked(7'h00);
    ram_read_checked(7'h7F);
  endtask

  task automatic test_gpio_counter();
    int highs;
    cnt_write_checked(CNT_MAX_ADDR, 32'd5);
    cnt_write_checked(CNT_COUNT_ADDR, 32'd0);
    cnt_read_checked(CNT_MAX_ADDR, 32'd5);
    repeat (3) gpio_rise_fall();
    cnt_read_checked(CNT_COUNT_ADDR, 32'd3);
    gpio_rise_fall();
    // Fifth edge reaches the maximum
    gpio_i = 1'b1;
    highs = 0;
    repeat (6) begin
      @(negedge clk_i);
      if (gpio_o) begin
        highs++;
      end
    end
    check_value("gpio_o pulse cycles", reg_bus_pkg::data_t'(highs), 32'd1);
    @(posedge clk_i);
    #(DRIVE_DELAY);
    gpio_i = 1'b0;
    repeat (LEVEL_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    cnt_read_checked(CNT_COUNT_ADDR, 32'd0);
    check_value("gpio_o pulses in run", reg_bus_pkg::data_t'(pulse_total), 32'd1);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    abort_run("watchdog expired");
  end

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i = '0;
    req_wdata_i = '0;
    gpio_i = 1'b0;
    seed = 32'hbdfe3ab5;
    model_written = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_n_i = 1'b1;
    test_reset_state();
    test_ram_single();
    test_ram_random();
    test_unmapped();
    test_gpio_counter();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hw/reg_bus_pkg.sv
hw/ext_periph_pkg.sv
hw/ext_periph_demux.sv
hw/slow_ram.sv
hw/gpio_cnt.sv
hw/ext_periph_top.sv
verif/ext_periph_properties.sv
verif/tb_ext_periph.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module tb_ext_periph -Mdir obj_dir \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_ext_periph > sim.log 2>&1
cat sim.log

grep -q "all tests passed" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
